// ==== vlog.f ====
mips_pkg.sv
mips_alu.sv
mips_control.sv
mips_regfile.sv
mips_core.sv
tb_mips_core.sv

// ==== mips_cases.hex ====
// core test vectors: instruction count, program words, store count,
// expected (address data) store pairs in order, then the pc expected after syscall
// instruction count
00000038
// sw r5 0x100, r5 untouched since reset
AC050100
// addi r1 0x7fff, addi r2 -1, add r3 r1 r2, sw r3 0x104
20017FFF 2002FFFF 00221820 AC030104
// sub r4 r0 r1, sw r4 0x108
00012022 AC040108
// lui r6 0x8000, addi r7 r6 -1 wraps, sw r7 0x10c
3C068000 20C7FFFF AC07010C
// slt r8 r6 r7 signed, sw r8 0x110
00C7402A AC080110
// slti r9 r2 0x8000 sign extended, sw r9 0x114
28498000 AC090114
// andi r10 r2 0x8f0f, ori r11 r10 0xf000, xori r12 r11 0xffff
304A8F0F 354BF000 396CFFFF
// sw r12 0x118, sw r10 0x11c
AC0C0118 AC0A011C
// or r13 r6 r1, xor r14 r13 r2, nor r15 r14 r1, and r16 r13 r2
00C16825 01A27026 01C17827 01A28024
// sw r15 0x120, sw r14 0x124, sw r16 0x128
AC0F0120 AC0E0124 AC100128
// sll r17 r1 4, srl r18 r6 31, sw r17 0x12c, sw r18 0x130
00018900 000697C2 AC11012C AC120130
// lui r19 0x1234, ori r19 0x5678, sw r19 0x40
3C131234 36735678 AC130040
// lw r20 0x40, addi r20 0x11, sw r20 0x44
8C140040 22940011 AC140044
// addi r0 0x55, sw r0 0x48
20000055 AC000048
// beq r1 r1 taken, marker 0x80 skipped
10210001 AC010080
// beq r1 r2 not taken, sw r8 0x84
10220001 AC080084
// bne r1 r2 taken, marker 0x88 skipped
14220001 AC010088
// bne r1 r1 not taken, sw r19 0x8c
14210001 AC13008C
// j 0xc0, marker 0x90 skipped
08000030 AC010090
// jal 0xcc, sw r31 0x94 on return, j 0xd8
0C000033 AC1F0094 08000036
// subroutine: sw r17 0x98, jr r31, marker 0x9c never reached
AC110098 03E00008 AC01009C
// syscall, marker 0xa0 after halt
0000000C AC0100A0
// store count
00000014
// expected stores, address then data
00000100 00000000
00000104 00007FFE
00000108 FFFF8001
0000010C 7FFFFFFF
00000110 00000001
00000114 00000000
00000118 000000F0
0000011C 00008F0F
00000120 80000000
00000124 7FFF8000
00000128 80007FFF
0000012C 0007FFF0
00000130 00000001
00000040 12345678
00000044 12345689
00000048 00000000
00000084 00000001
0000008C 12345678
00000098 0007FFF0
00000094 000000C4
// final pc, syscall address plus 4
000000DC

// ==== tb_mips_core.sv ====
// testbench for mips_core; models both memories and checks stores and halt from mips_cases.hex
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*; ();

    localparam int case_words     = 256;
    localparam int dmem_words     = 256;
    localparam int reset_cycles   = 16;
    localparam int timeout_cycles = 2000;
    localparam int hold_cycles    = 20;

    // first fetch address while in reset
    localparam word_t boot_pc = 32'h0000_0000;

    logic        clk;
    logic        rst_b;
    word_t       inst;
    word_t       inst_addr;
    word_t       mem_addr;
    byte_lanes_t mem_data_out;
    byte_lanes_t mem_data_in;
    logic        mem_write_en;
    logic        halted;

    // flat image of the cases file
    word_t       cases [case_words];
    byte_lanes_t dmem [dmem_words];

    // layout pulled out of the cases image
    int    n_inst;
    int    n_store;
    int    store_base;
    word_t final_pc;

    int store_idx;
    int errors;
    int timeouts;

    // 40 ns period
    initial clk = 1'b0;
    always #20 clk = ~clk;

    mips_core dut (
        .clk          (clk),
        .rst_b        (rst_b),
        .inst         (inst),
        .inst_addr    (inst_addr),
        .mem_addr     (mem_addr),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_write_en (mem_write_en),
        .halted       (halted)
    );

    // instruction memory, zero word past the program acts as a no-op
    always_comb begin
        if (inst_addr[31:2] < n_inst) begin
            inst = cases[1 + inst_addr[31:2]];
        end else begin
            inst = '0;
        end
    end

    // data memory, word indexed, combinational read
    assign mem_data_out = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_write_en) begin
            dmem[mem_addr[9:2]] <= mem_data_in;
        end
    end

    // pick counts and offsets out of the image
    task parse_cases();
        assert (!$isunknown(cases[0])) else begin
            errors++;
            $display("case file mips_cases.hex could not be read");
        end
        n_inst     = cases[0];
        n_store    = cases[n_inst + 1];
        store_base = n_inst + 2;
        final_pc   = cases[store_base + 2 * n_store];
    endtask

    // outputs held while rst_b is low
    task check_reset_outputs();
        assert (inst_addr == boot_pc) else begin
            errors++;
            $display("[FAIL] inst_addr in reset got %h expected %h", inst_addr, boot_pc);
        end
        assert (halted == 1'b0) else begin
            errors++;
            $display("[FAIL] halted in reset got %h expected %h", halted, 1'b0);
        end
        assert (mem_write_en == 1'b0) else begin
            errors++;
            $display("[FAIL] mem_write_en in reset got %h expected %h", mem_write_en, 1'b0);
        end
    endtask

    // one store against the next listed pair
    task check_store();
        word_t exp_addr;
        word_t exp_data;
        assert (!halted) else begin
            errors++;
            $display("store to %h issued after the core halted", mem_addr);
        end
        assert (store_idx < n_store) else begin
            errors++;
            $display("unexpected store to %h beyond the %0d listed stores", mem_addr, n_store);
        end
        if (store_idx < n_store) begin
            exp_addr = cases[store_base + 2 * store_idx];
            exp_data = cases[store_base + 2 * store_idx + 1];
            assert (mem_addr == exp_addr) else begin
                errors++;
                $display("[FAIL] mem_addr store %0d got %h expected %h",
                         store_idx, mem_addr, exp_addr);
            end
            assert (word_t'(mem_data_in) == exp_data) else begin
                errors++;
                $display("[FAIL] mem_data_in store %0d got %h expected %h",
                         store_idx, word_t'(mem_data_in), exp_data);
            end
            // lane 0 carries the top byte
            assert (mem_data_in[0] == exp_data[31:24]) else begin
                errors++;
                $display("[FAIL] mem_data_in[0] store %0d got %h expected %h",
                         store_idx, mem_data_in[0], exp_data[31:24]);
            end
        end
        store_idx++;
    endtask

    // sampled mid-cycle, the store commits on the next rising edge
    always @(negedge clk) begin
        if (rst_b && mem_write_en) begin
            check_store();
        end
    end

    initial begin
        int cycles;
        rst_b     = 1'b0;
        errors    = 0;
        timeouts  = 0;
        store_idx = 0;
        n_inst    = 0;
        n_store   = 0;
        // fill tied to the word address
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = byte_lanes_t'(32'hd0d0_0000 ^ (i << 2));
        end
        $readmemh("mips_cases.hex", cases);
        parse_cases();

        // reset for 16 rising edges, outputs checked each low phase
        repeat (reset_cycles) begin
            @(negedge clk);
            check_reset_outputs();
        end
        @(posedge clk);
        rst_b <= 1'b1;

        // run until syscall
        cycles = 0;
        while (!halted && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        assert (halted) else begin
            timeouts++;
            $display("timeout, halted never rose within %0d cycles", timeout_cycles);
        end

        // pc must park on syscall + 4
        if (halted) begin
            for (int i = 0; i <= hold_cycles; i++) begin
                assert (inst_addr == final_pc) else begin
                    errors++;
                    $display("[FAIL] inst_addr after halt got %h expected %h",
                             inst_addr, final_pc);
                end
                assert (halted) else begin
                    errors++;
                    $display("[FAIL] halted after halt got %h expected %h", halted, 1'b1);
                end
                @(negedge clk);
            end
        end

        assert (store_idx == n_store) else begin
            errors++;
            $display("[FAIL] store count got %h expected %h", store_idx, n_store);
        end

        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== mips_core.sv ====
// single-cycle mips core top; connect instruction and data memory to its ports
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
    input  logic        clk,
    input  logic        rst_b,
    input  word_t       inst,
    output word_t       inst_addr,
    output word_t       mem_addr,
    input  byte_lanes_t mem_data_out,
    output byte_lanes_t mem_data_in,
    output logic        mem_write_en,
    output logic        halted
);

    // instruction fields
    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_num_t    rs_num;
    reg_num_t    rt_num;
    reg_num_t    rd_field;
    logic [4:0]  shamt_field;
    logic [15:0] imm;
    logic [25:0] jump_index;

    // decoded controls
    ctrl_t ctrl;

    // pc and next-pc path
    word_t pc;
    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    word_t next_pc;
    logic  branch_taken;

    // datapath
    word_t    imm_ext;
    word_t    rs_data;
    word_t    rt_data;
    word_t    alu_in2;
    logic [4:0] alu_shamt;
    word_t    alu_result;
    logic     alu_zero;
    word_t    load_word;
    reg_num_t wr_num;
    word_t    wr_data;
    logic     wr_en;

    assign opcode      = inst[31:26];
    assign rs_num      = inst[25:21];
    assign rt_num      = inst[20:16];
    assign rd_field    = inst[15:11];
    assign shamt_field = inst[10:6];
    assign funct       = inst[5:0];
    assign imm         = inst[15:0];
    assign jump_index  = inst[25:0];

    mips_control u_control (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrl)
    );

    // immediate extension, logical ops and lui take zero fill
    assign imm_ext = ctrl.zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

    assign pc_plus4      = pc + 32'd4;
    // word offset relative to the following instruction
    assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
    // region bits from pc+4, then the index, then word alignment
    assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

    // beq wants zero, bne wants nonzero
    assign branch_taken = ctrl.branch && (alu_zero != ctrl.branch_ne);

    // jr wins, then jump, then branch
    always_comb begin
        if (ctrl.jump_reg) begin
            next_pc = rs_data;
        end else if (ctrl.jump) begin
            next_pc = jump_target;
        end else if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // pc and halt flag
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            pc     <= reset_pc;
            halted <= 1'b0;
        end else if (!halted) begin
            // syscall falls through to pc+4 and freezes there
            pc     <= next_pc;
            halted <= ctrl.syscall;
        end
    end

    assign inst_addr = pc;

    // second operand and shift amount
    assign alu_in2   = ctrl.alu_src ? imm_ext : rt_data;
    assign alu_shamt = ctrl.shift_imm ? shamt_field : 5'd0;

    mips_alu u_alu (
        .in1        (rs_data),
        .in2        (alu_in2),
        .shamt      (alu_shamt),
        .alu_op     (ctrl.alu_op),
        .alu_result (alu_result),
        .zero       (alu_zero)
    );

    // write target, jal links into r31
    always_comb begin
        if (ctrl.link) begin
            wr_num = ra_num;
        end else if (ctrl.reg_dst) begin
            wr_num = rd_field;
        end else begin
            wr_num = rt_num;
        end
    end

    // lanes are big-endian so the word maps straight across
    assign load_word = word_t'(mem_data_out);

    always_comb begin
        if (ctrl.link) begin
            wr_data = pc_plus4;
        end else if (ctrl.mem_to_reg) begin
            wr_data = load_word;
        end else begin
            wr_data = alu_result;
        end
    end

    // no writes once halted or in reset
    assign wr_en = ctrl.reg_write && !halted && rst_b;

    mips_regfile u_regfile (
        .clk     (clk),
        .rst_b   (rst_b),
        .rs_num  (rs_num),
        .rt_num  (rt_num),
        .rd_num  (wr_num),
        .rd_data (wr_data),
        .rd_we   (wr_en),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // data memory side
    assign mem_addr     = alu_result;
    assign mem_data_in  = byte_lanes_t'(rt_data);
    assign mem_write_en = ctrl.mem_write && !halted && rst_b;

    // a bad jr target would show up here first
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_b)
        inst_addr[1:0] == 2'b00
    ) else $error("inst_addr not word aligned, %h", inst_addr);

    // store traffic must stop for good after syscall
    a_no_store_halted: assert property (
        @(posedge clk) disable iff (!rst_b)
        halted |-> !mem_write_en
    ) else $error("store while halted, addr %h", mem_addr);

endmodule

// ==== mips_regfile.sv ====
// 32-entry register file, two combinational read ports and one clocked write port; r0 reads zero
`timescale 1ns/1ps

module mips_regfile import mips_pkg::*; (
    input  logic     clk,
    input  logic     rst_b,
    input  reg_num_t rs_num,
    input  reg_num_t rt_num,
    input  reg_num_t rd_num,
    input  word_t    rd_data,
    input  logic     rd_we,
    output word_t    rs_data,
    output word_t    rt_data
);

    word_t regs [num_regs];

    // whole file clears on reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_num != '0)) begin
            // r0 writes dropped here
            regs[rd_num] <= rd_data;
        end
    end

    // asynchronous reads, new value seen after the edge
    assign rs_data = regs[rs_num];
    assign rt_data = regs[rt_num];

    // r0 stays hardwired even when the core targets it
    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_b)
        (rd_we && (rd_num == '0)) |=> (regs[0] == '0)
    ) else $error("r0 changed after write, now %h", regs[0]);

endmodule

// ==== mips_control.sv ====
// main decoder with folded alu control; maps opcode and funct onto the ctrl_t struct for the core
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output ctrl_t      ctrl
);

    always_comb begin
        // start from an inactive struct so unknown codes fall through as no-ops
        ctrl = '0;
        case (opcode)
            op_rtype: begin
                // register-register ops write rd
                case (funct)
                    fn_add: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_add;
                    end
                    fn_sub: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_sub;
                    end
                    fn_and: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_and;
                    end
                    fn_or: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_or;
                    end
                    fn_xor: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_xor;
                    end
                    fn_nor: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_nor;
                    end
                    fn_slt: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = alu_slt;
                    end
                    // shifts take the amount from the shamt field
                    fn_sll: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.shift_imm = 1'b1;
                        ctrl.alu_op    = alu_sll;
                    end
                    fn_srl: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.shift_imm = 1'b1;
                        ctrl.alu_op    = alu_srl;
                    end
                    fn_jr:      ctrl.jump_reg = 1'b1;
                    fn_syscall: ctrl.syscall  = 1'b1;
                    default:    ctrl = '0;
                endcase
            end
            // immediate arithmetic, sign extended
            op_addi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            op_slti: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_slt;
            end
            // logical immediates zero extend
            op_andi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_and;
            end
            op_ori: begin
                ctrl.alu_src   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_or;
            end
            op_xori: begin
                ctrl.alu_src   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_xor;
            end
            op_lui: begin
                ctrl.alu_src   = 1'b1;
                ctrl.zero_ext  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_lui;
            end
            // memory, address is base plus offset
            op_lw: begin
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.alu_op     = alu_add;
            end
            op_sw: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = alu_add;
            end
            // branches compare by subtraction
            op_beq: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = alu_sub;
            end
            op_bne: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = alu_sub;
            end
            op_j:   ctrl.jump = 1'b1;
            op_jal: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // next-pc mux in the core assumes at most one of these per instruction
    a_jump_xor_branch: assert final (!(ctrl.jump && ctrl.branch))
        else $error("decoder drives jump and branch together, opcode %h", opcode);

endmodule

// ==== mips_alu.sv ====
// combinational alu for the single-cycle core; operands come from the core's muxes
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
    input  word_t       in1,
    input  word_t       in2,
    input  logic [4:0]  shamt,
    input  alu_op_t     alu_op,
    output word_t       alu_result,
    output logic        zero
);

    // signed views for slt
    logic signed [31:0] in1_s;
    logic signed [31:0] in2_s;

    assign in1_s = in1;
    assign in2_s = in2;

    always_comb begin
        case (alu_op)
            // wrap-around, no overflow trap
            alu_add: alu_result = in1 + in2;
            alu_sub: alu_result = in1 - in2;
            alu_and: alu_result = in1 & in2;
            alu_or:  alu_result = in1 | in2;
            alu_xor: alu_result = in1 ^ in2;
            alu_nor: alu_result = ~(in1 | in2);
            // result is 1 or 0
            alu_slt: alu_result = {31'b0, (in1_s < in2_s)};
            // shifts act on the second operand
            alu_sll: alu_result = in2 << shamt;
            alu_srl: alu_result = in2 >> shamt;
            // immediate into the upper half
            alu_lui: alu_result = {in2[15:0], 16'h0000};
            default: alu_result = '0;
        endcase
    end

    // used by beq and bne
    assign zero = (alu_result == '0);

endmodule

// ==== mips_pkg.sv ====
// shared types, opcode and funct encodings and decoded controls; import into every core block
package mips_pkg;

    // basic data types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_num_t;

    // big-endian lanes, lane 0 holds bits 31:24
    typedef logic [0:3][7:0] byte_lanes_t;

    // register file depth, fixed by the ISA
    localparam int num_regs = 32;

    // link register for jal
    localparam reg_num_t ra_num = 5'd31;

    // pc after reset
    localparam word_t reset_pc = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_j     = 6'h02;
    localparam logic [5:0] op_jal   = 6'h03;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_slti  = 6'h0a;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_xori  = 6'h0e;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // r-type funct codes
    localparam logic [5:0] fn_sll     = 6'h00;
    localparam logic [5:0] fn_srl     = 6'h02;
    localparam logic [5:0] fn_jr      = 6'h08;
    localparam logic [5:0] fn_syscall = 6'h0c;
    localparam logic [5:0] fn_add     = 6'h20;
    localparam logic [5:0] fn_sub     = 6'h22;
    localparam logic [5:0] fn_and     = 6'h24;
    localparam logic [5:0] fn_or      = 6'h25;
    localparam logic [5:0] fn_xor     = 6'h26;
    localparam logic [5:0] fn_nor     = 6'h27;
    localparam logic [5:0] fn_slt     = 6'h2a;

    // alu operations, add is the all-zero default
    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_nor = 4'd5,
        alu_slt = 4'd6,
        alu_sll = 4'd7,
        alu_srl = 4'd8,
        alu_lui = 4'd9
    } alu_op_t;

    // decoded controls, all zero means no-op
    typedef struct packed {
        logic    reg_dst;
        logic    link;
        logic    alu_src;
        logic    zero_ext;
        alu_op_t alu_op;
        logic    mem_to_reg;
        logic    reg_write;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    jump_reg;
        logic    shift_imm;
        logic    syscall;
    } ctrl_t;

endpackage
